// File: include/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Datapath width of operands and results
`define DATA_WIDTH 32

// Operation code widths
`define ALUCONTROL_WIDTH 5
`define MAC_OP_WIDTH 3

// Number of status flag bits
`define ALU_FLAGS_WIDTH 5

// Signed 32-bit limits used by QADD and QSUB
`define SAT_MAX 32'h7FFF_FFFF
`define SAT_MIN 32'h8000_0000

// Shift-add multiplier runs one iteration per operand bit
`define MAC_ITERATIONS 32

`endif

// File: hdl/exec_pkg.sv
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

  // ALU control encodings with codes 8 to 13 and 31 reserved
  typedef enum logic [`ALUCONTROL_WIDTH-1:0] {
    ALU_ADD    = 5'd0,
    ALU_ADC    = 5'd1,
    ALU_QADD   = 5'd2,
    ALU_SUB    = 5'd3,
    ALU_SBC    = 5'd4,
    ALU_RSB    = 5'd5,
    ALU_QSUB   = 5'd6,
    ALU_MUL    = 5'd7,
    ALU_UDIV   = 5'd14,
    ALU_SDIV   = 5'd15,
    ALU_AND    = 5'd16,
    ALU_BIC    = 5'd17,
    ALU_ORR    = 5'd18,
    ALU_ORN    = 5'd19,
    ALU_EOR    = 5'd20,
    ALU_CMN    = 5'd21,
    ALU_TST    = 5'd22,
    ALU_TEQ    = 5'd23,
    ALU_CMP    = 5'd24,
    ALU_MOV    = 5'd25,
    ALU_RSHIFT = 5'd26,
    ALU_ASHIFT = 5'd27,
    ALU_LSHIFT = 5'd28,
    ALU_ROR    = 5'd29,
    ALU_RRX    = 5'd30
  } aluOp_t;

  // Multiply-accumulate operations
  typedef enum logic [`MAC_OP_WIDTH-1:0] {
    MAC_MLA,
    MAC_MLS,
    MAC_UMULL,
    MAC_UMLAL,
    MAC_SMULL,
    MAC_SMLAL
  } macOp_t;

  // Flag bits from saturated down to overflow
  typedef struct packed {
    logic saturated;
    logic neg;
    logic zero;
    logic carry;
    logic overflow;
  } aluFlags_t;

  typedef struct packed {
    logic                   useMac;
    aluOp_t                 aluOp;
    macOp_t                 macOp;
    logic                   setFlags;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    logic [`DATA_WIDTH-1:0] accLo;
    logic [`DATA_WIDTH-1:0] accHi;
  } execReq_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] resultLo;
    logic [`DATA_WIDTH-1:0] resultHi;
    aluFlags_t              flags;
  } execResp_t;

endpackage

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module alu
  import exec_pkg::*;
(
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  input  aluOp_t                 aluControl,
  input  logic                   carryIn,
  output logic [`DATA_WIDTH-1:0] result,
  output aluFlags_t              aluFlags
);

  // One adder serves every add and subtract form
  logic [`DATA_WIDTH-1:0] addX;
  logic [`DATA_WIDTH-1:0] addY;
  logic                   addCin;
  logic [`DATA_WIDTH:0]   addSum;
  logic                   addOverflow;

  logic [4:0]             shiftAmt;
  logic                   shiftZero;
  logic [`DATA_WIDTH:0]   lslWide;
  logic [`DATA_WIDTH:0]   lsrWide;
  logic [`DATA_WIDTH:0]   asrWide;
  logic [`DATA_WIDTH-1:0] rorResult;

  logic [`DATA_WIDTH-1:0] udivResult;
  logic [`DATA_WIDTH-1:0] sdivResult;
  logic [`DATA_WIDTH-1:0] satResult;

  logic                   carry;
  logic                   overflow;
  logic                   saturated;

  // Subtraction is a + ~b + 1, so carry set means no borrow
  always_comb begin
    addX   = a;
    addY   = b;
    addCin = 1'b0;
    case (aluControl)
      ALU_ADC: addCin = carryIn;
      ALU_SUB, ALU_QSUB, ALU_CMP: begin
        addY   = ~b;
        addCin = 1'b1;
      end
      ALU_SBC: begin
        addY   = ~b;
        addCin = carryIn;
      end
      ALU_RSB: begin
        addX   = b;
        addY   = ~a;
        addCin = 1'b1;
      end
      default: ;
    endcase
  end

  assign addSum = {1'b0, addX} + {1'b0, addY} + {{`DATA_WIDTH{1'b0}}, addCin};
  assign addOverflow = (addX[`DATA_WIDTH-1] == addY[`DATA_WIDTH-1]) &&
                       (addSum[`DATA_WIDTH-1] != addX[`DATA_WIDTH-1]);

  // Clamp direction follows the sign of the first operand
  assign satResult = a[`DATA_WIDTH-1] ? `SAT_MIN : `SAT_MAX;

  assign udivResult = (b != '0) ? (a / b) : '0;
  assign sdivResult = (b != '0) ? $unsigned($signed(a) / $signed(b)) : '0;

  assign shiftAmt  = b[4:0];
  assign shiftZero = (shiftAmt == 5'd0);

  // Extra bit on the far side catches the last bit shifted out
  assign lslWide   = {1'b0, a} << shiftAmt;
  assign lsrWide   = {a, 1'b0} >> shiftAmt;
  assign asrWide   = $unsigned($signed({a, 1'b0}) >>> shiftAmt);
  assign rorResult = (a >> shiftAmt) | (a << (6'd`DATA_WIDTH - {1'b0, shiftAmt}));

  always_comb begin
    result    = '0;
    carry     = carryIn;
    overflow  = 1'b0;
    saturated = 1'b0;
    case (aluControl)
      ALU_ADD, ALU_ADC, ALU_CMN, ALU_SUB, ALU_SBC, ALU_RSB, ALU_CMP: begin
        result   = addSum[`DATA_WIDTH-1:0];
        carry    = addSum[`DATA_WIDTH];
        overflow = addOverflow;
      end
      ALU_QADD, ALU_QSUB: begin
        result    = addOverflow ? satResult : addSum[`DATA_WIDTH-1:0];
        carry     = addSum[`DATA_WIDTH];
        saturated = addOverflow;
      end
      ALU_MUL:  result = a * b;
      ALU_UDIV: result = udivResult;
      ALU_SDIV: result = sdivResult;
      ALU_AND, ALU_TST: result = a & b;
      ALU_BIC:  result = a & ~b;
      ALU_ORR:  result = a | b;
      ALU_ORN:  result = a | ~b;
      ALU_EOR, ALU_TEQ: result = a ^ b;
      ALU_MOV:  result = b;
      ALU_LSHIFT: begin
        result = lslWide[`DATA_WIDTH-1:0];
        if (!shiftZero) begin
          carry = lslWide[`DATA_WIDTH];
        end
      end
      ALU_RSHIFT: begin
        result = lsrWide[`DATA_WIDTH:1];
        if (!shiftZero) begin
          carry = lsrWide[0];
        end
      end
      ALU_ASHIFT: begin
        result = asrWide[`DATA_WIDTH:1];
        if (!shiftZero) begin
          carry = asrWide[0];
        end
      end
      ALU_ROR: begin
        result = rorResult;
        // Last bit out lands in the top position
        if (!shiftZero) begin
          carry = rorResult[`DATA_WIDTH-1];
        end
      end
      ALU_RRX: begin
        result = {carryIn, a[`DATA_WIDTH-1:1]};
        carry  = a[0];
      end
      // Reserved codes
      default: result = '0;
    endcase
  end

  assign aluFlags.saturated = saturated;
  assign aluFlags.neg       = result[`DATA_WIDTH-1];
  assign aluFlags.zero      = (result == '0);
  assign aluFlags.carry     = carry;
  assign aluFlags.overflow  = overflow;

endmodule

`default_nettype wire

// File: hdl/mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module mac
  import exec_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   macReq,
  input  macOp_t                 macOp,
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  input  logic [`DATA_WIDTH-1:0] accLo,
  input  logic [`DATA_WIDTH-1:0] accHi,
  output logic                   macAck,
  output logic [`DATA_WIDTH-1:0] productLo,
  output logic [`DATA_WIDTH-1:0] productHi
);

  typedef enum logic [1:0] {MAC_IDLE, MAC_MULT, MAC_ACCUM, MAC_DONE} macState_t;

  macState_t                state;
  logic [4:0]               bitCount;
  logic [2*`DATA_WIDTH-1:0] mcand;
  logic [`DATA_WIDTH-1:0]   mplier;
  logic [2*`DATA_WIDTH-1:0] prodAcc;
  logic                     negate;

  logic                     signedForm;
  logic [`DATA_WIDTH-1:0]   magA;
  logic [`DATA_WIDTH-1:0]   magB;
  logic [2*`DATA_WIDTH-1:0] signedProd;
  logic [2*`DATA_WIDTH-1:0] accWide;

  // Only the long signed forms need magnitudes
  assign signedForm = (macOp == MAC_SMULL) || (macOp == MAC_SMLAL);
  assign magA = (signedForm && a[`DATA_WIDTH-1]) ? -a : a;
  assign magB = (signedForm && b[`DATA_WIDTH-1]) ? -b : b;

  assign signedProd = negate ? -prodAcc : prodAcc;

  always_comb begin
    case (macOp)
      MAC_MLA: accWide = {{`DATA_WIDTH{1'b0}}, signedProd[`DATA_WIDTH-1:0] + accLo};
      MAC_MLS: accWide = {{`DATA_WIDTH{1'b0}}, accLo - signedProd[`DATA_WIDTH-1:0]};
      MAC_UMLAL, MAC_SMLAL: accWide = signedProd + {accHi, accLo};
      default: accWide = signedProd;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= MAC_IDLE;
      bitCount <= '0;
    end else begin
      case (state)
        MAC_IDLE: begin
          bitCount <= '0;
          if (macReq) begin
            state <= MAC_MULT;
          end
        end
        MAC_MULT: begin
          bitCount <= bitCount + 5'd1;
          if (bitCount == 5'(`MAC_ITERATIONS - 1)) begin
            state <= MAC_ACCUM;
          end
        end
        MAC_ACCUM: state <= MAC_DONE;
        // Hold ack until the requester drops macReq
        MAC_DONE: begin
          if (!macReq) begin
            state <= MAC_IDLE;
          end
        end
        default: state <= MAC_IDLE;
      endcase
    end
  end

  // Shift-add datapath
  always_ff @(posedge clk) begin
    case (state)
      MAC_IDLE: begin
        if (macReq) begin
          mcand   <= {{`DATA_WIDTH{1'b0}}, magA};
          mplier  <= magB;
          prodAcc <= '0;
          negate  <= signedForm && (a[`DATA_WIDTH-1] ^ b[`DATA_WIDTH-1]);
        end
      end
      MAC_MULT: begin
        if (mplier[0]) begin
          prodAcc <= prodAcc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
      MAC_ACCUM: begin
        productLo <= accWide[`DATA_WIDTH-1:0];
        productHi <= accWide[2*`DATA_WIDTH-1:`DATA_WIDTH];
      end
      default: ;
    endcase
  end

  assign macAck = (state == MAC_DONE);

  // Operation select must not move during a handshake
  macOpStable: assert property (@(posedge clk) disable iff (reset)
    (macReq && $past(macReq)) |-> $stable(macOp))
    else $error("macOp changed while macReq was high");

endmodule

`default_nettype wire

// File: hdl/execSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module execSequencer
  import exec_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req,
  input  execReq_t               request,
  output logic                   ack,
  output execResp_t              response,
  output aluFlags_t              statusFlags,
  output logic [`DATA_WIDTH-1:0] aluA,
  output logic [`DATA_WIDTH-1:0] aluB,
  output aluOp_t                 aluControl,
  output logic                   carryIn,
  input  logic [`DATA_WIDTH-1:0] aluResult,
  input  aluFlags_t              aluFlags,
  output logic                   macReq,
  input  logic                   macAck,
  output macOp_t                 macOp,
  output logic [`DATA_WIDTH-1:0] macA,
  output logic [`DATA_WIDTH-1:0] macB,
  output logic [`DATA_WIDTH-1:0] macAccLo,
  output logic [`DATA_WIDTH-1:0] macAccHi,
  input  logic [`DATA_WIDTH-1:0] productLo,
  input  logic [`DATA_WIDTH-1:0] productHi
);

  // ALU ops leave SEQ_WAIT after one cycle and MAC ops wait for macAck
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_WAIT, SEQ_ACK} seqState_t;

  seqState_t state;
  execReq_t  held;
  logic      finish;
  logic      longForm;
  aluFlags_t macFlags;
  aluFlags_t resultFlags;
  aluFlags_t nextStatus;

  assign finish = (state == SEQ_WAIT) && (!held.useMac || macAck);

  // MAC results replace only N and Z, taken from the high word of 64-bit forms
  always_comb begin
    longForm      = held.macOp inside {MAC_UMULL, MAC_UMLAL, MAC_SMULL, MAC_SMLAL};
    macFlags      = statusFlags;
    macFlags.neg  = longForm ? productHi[`DATA_WIDTH-1] : productLo[`DATA_WIDTH-1];
    macFlags.zero = longForm ? (productHi == '0) : (productLo == '0);
    resultFlags   = held.useMac ? macFlags : aluFlags;
    nextStatus    = resultFlags;
    // Q is sticky
    nextStatus.saturated = resultFlags.saturated | statusFlags.saturated;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= SEQ_IDLE;
      macReq      <= 1'b0;
      statusFlags <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (req) begin
            state  <= SEQ_WAIT;
            macReq <= request.useMac;
          end
        end
        SEQ_WAIT: begin
          if (finish) begin
            state  <= SEQ_ACK;
            macReq <= 1'b0;
            if (held.setFlags) begin
              statusFlags <= nextStatus;
            end
          end
        end
        SEQ_ACK: begin
          if (!req) begin
            state <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SEQ_IDLE && req) begin
      held <= request;
    end
    if (finish) begin
      response.resultLo <= held.useMac ? productLo : aluResult;
      response.resultHi <= held.useMac ? productHi : '0;
      response.flags    <= resultFlags;
    end
  end

  assign ack        = (state == SEQ_ACK);
  assign aluA       = held.a;
  assign aluB       = held.b;
  assign aluControl = held.aluOp;
  assign carryIn    = statusFlags.carry;
  assign macOp      = held.macOp;
  assign macA       = held.a;
  assign macB       = held.b;
  assign macAccLo   = held.accLo;
  assign macAccHi   = held.accHi;

  ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> req)
    else $error("ack rose without req");

  noReservedOp: assert property (@(posedge clk) disable iff (reset)
    (state == SEQ_IDLE && req && !request.useMac) |->
      !(request.aluOp inside {[5'd8:5'd13], 5'd31}))
    else $error("reserved ALU code accepted");

  requestStable: assert property (@(posedge clk) disable iff (reset)
    (req && !ack && $past(req && !ack)) |-> $stable(request))
    else $error("request changed before ack");

endmodule

`default_nettype wire

// File: hdl/execStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module execStage
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req,
  input  execReq_t  request,
  output logic      ack,
  output execResp_t response,
  output aluFlags_t statusFlags
);

  // Sequencer to ALU
  logic [`DATA_WIDTH-1:0] aluA;
  logic [`DATA_WIDTH-1:0] aluB;
  aluOp_t                 aluControl;
  logic                   carryIn;
  logic [`DATA_WIDTH-1:0] aluResult;
  aluFlags_t              aluFlags;

  // Sequencer to MAC
  logic                   macReq;
  logic                   macAck;
  macOp_t                 macOp;
  logic [`DATA_WIDTH-1:0] macA;
  logic [`DATA_WIDTH-1:0] macB;
  logic [`DATA_WIDTH-1:0] macAccLo;
  logic [`DATA_WIDTH-1:0] macAccHi;
  logic [`DATA_WIDTH-1:0] productLo;
  logic [`DATA_WIDTH-1:0] productHi;

  execSequencer i_execSequencer (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .request     (request),
    .ack         (ack),
    .response    (response),
    .statusFlags (statusFlags),
    .aluA        (aluA),
    .aluB        (aluB),
    .aluControl  (aluControl),
    .carryIn     (carryIn),
    .aluResult   (aluResult),
    .aluFlags    (aluFlags),
    .macReq      (macReq),
    .macAck      (macAck),
    .macOp       (macOp),
    .macA        (macA),
    .macB        (macB),
    .macAccLo    (macAccLo),
    .macAccHi    (macAccHi),
    .productLo   (productLo),
    .productHi   (productHi)
  );

  alu i_alu (
    .a          (aluA),
    .b          (aluB),
    .aluControl (aluControl),
    .carryIn    (carryIn),
    .result     (aluResult),
    .aluFlags   (aluFlags)
  );

  mac i_mac (
    .clk       (clk),
    .reset     (reset),
    .macReq    (macReq),
    .macOp     (macOp),
    .a         (macA),
    .b         (macB),
    .accLo     (macAccLo),
    .accHi     (macAccHi),
    .macAck    (macAck),
    .productLo (productLo),
    .productHi (productHi)
  );

endmodule

`default_nettype wire

// File: testbench/tb_execStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module tb_execStage
  import exec_pkg::*;
;

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 10;
  localparam int ARITH_REPS   = 8;
  localparam int SAT_REPS     = 8;
  localparam int DIV_REPS     = 8;
  localparam int LOGIC_REPS   = 4;
  localparam int RRX_REPS     = 8;
  localparam int MAC_REPS     = 6;
  localparam int FLAG_REPS    = 8;
  localparam int HOLD_CYCLES  = 5;
  localparam int TOTAL_OPS    = 8 * ARITH_REPS + 4 + SAT_REPS + 2 + 2 * DIV_REPS +
                                8 * LOGIC_REPS + 4 * 32 + RRX_REPS + 6 * MAC_REPS +
                                FLAG_REPS + 2;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 40 + 2 * RESET_CYCLES + HOLD_CYCLES;

  logic      clk;
  logic      reset;
  logic      req;
  execReq_t  request;
  logic      ack;
  execResp_t response;
  aluFlags_t statusFlags;

  // Expected values for the operation in flight
  execResp_t   expResp;
  aluFlags_t   expStatus;
  aluFlags_t   modelStatus;
  logic        curUseMac;
  logic        curSetFlags;
  string       testName;
  int          errorCount;
  logic [31:0] rngState;

  logic [31:0] corners[5] = '{32'd0, 32'd1, `SAT_MAX, `SAT_MIN, 32'hFFFF_FFFF};
  aluOp_t arithOps[8] = '{ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_RSB, ALU_CMP,
                          ALU_CMN, ALU_MUL};
  aluOp_t logicOps[8] = '{ALU_AND, ALU_BIC, ALU_ORR, ALU_ORN, ALU_EOR, ALU_TST,
                          ALU_TEQ, ALU_MOV};
  aluOp_t shiftOps[4] = '{ALU_LSHIFT, ALU_RSHIFT, ALU_ASHIFT, ALU_ROR};
  macOp_t macOps[6] = '{MAC_MLA, MAC_MLS, MAC_UMULL, MAC_UMLAL, MAC_SMULL, MAC_SMLAL};

  execStage i_execStage (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .request     (request),
    .ack         (ack),
    .response    (response),
    .statusFlags (statusFlags)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // Roughly one operand in four is a corner value
  function automatic logic [31:0] pickOperand();
    logic [31:0] r;
    r = nextRandom();
    if (r[1:0] == 2'b00) begin
      return corners[r[10:2] % 5];
    end
    return nextRandom();
  endfunction

  function automatic execReq_t aluReq(input aluOp_t op, input logic [31:0] a,
                                      input logic [31:0] b, input logic setFlags);
    execReq_t r;
    r = '0;
    r.aluOp    = op;
    r.a        = a;
    r.b        = b;
    r.setFlags = setFlags;
    return r;
  endfunction

  function automatic execReq_t macReqFor(input macOp_t op, input logic [31:0] a,
                                         input logic [31:0] b, input logic [31:0] lo,
                                         input logic [31:0] hi);
    execReq_t r;
    r = '0;
    r.useMac   = 1'b1;
    r.macOp    = op;
    r.a        = a;
    r.b        = b;
    r.accLo    = lo;
    r.accHi    = hi;
    r.setFlags = 1'b1;
    return r;
  endfunction

  // Reference ALU built on 64-bit integer arithmetic
  function automatic void aluModel(input execReq_t r, input logic cin,
                                   output logic [31:0] res, output aluFlags_t fl);
    longint ua;
    longint ub;
    longint sa;
    longint sb;
    longint u;
    longint s;
    longint extra;
    logic   arith;
    logic   ovf;
    int     amt;
    ua    = longint'(r.a);
    ub    = longint'(r.b);
    sa    = longint'($signed(r.a));
    sb    = longint'($signed(r.b));
    amt   = int'(r.b[4:0]);
    arith = 1'b0;
    u     = 0;
    s     = 0;
    res   = '0;
    fl    = '0;
    fl.carry = cin;
    case (r.aluOp)
      ALU_ADD, ALU_ADC, ALU_CMN, ALU_QADD: begin
        extra    = (r.aluOp == ALU_ADC) ? longint'(cin) : 0;
        u        = ua + ub + extra;
        s        = sa + sb + extra;
        fl.carry = (u > 64'sh0_FFFF_FFFF);
        arith    = 1'b1;
      end
      ALU_SUB, ALU_SBC, ALU_CMP, ALU_QSUB: begin
        extra    = (r.aluOp == ALU_SBC) ? longint'(!cin) : 0;
        u        = ua - ub - extra;
        s        = sa - sb - extra;
        fl.carry = (u >= 0);
        arith    = 1'b1;
      end
      ALU_RSB: begin
        u        = ub - ua;
        s        = sb - sa;
        fl.carry = (u >= 0);
        arith    = 1'b1;
      end
      ALU_MUL:  res = r.a * r.b;
      ALU_UDIV: res = (r.b == 0) ? 32'd0 : r.a / r.b;
      ALU_SDIV: res = (r.b == 0) ? 32'd0 : 32'(sa / sb);
      ALU_AND, ALU_TST: res = r.a & r.b;
      ALU_BIC:  res = r.a & ~r.b;
      ALU_ORR:  res = r.a | r.b;
      ALU_ORN:  res = r.a | ~r.b;
      ALU_EOR, ALU_TEQ: res = r.a ^ r.b;
      ALU_MOV:  res = r.b;
      ALU_LSHIFT: begin
        res = r.a << amt;
        if (amt != 0) fl.carry = r.a[32 - amt];
      end
      ALU_RSHIFT: begin
        res = r.a >> amt;
        if (amt != 0) fl.carry = r.a[amt - 1];
      end
      ALU_ASHIFT: begin
        res = $unsigned($signed(r.a) >>> amt);
        if (amt != 0) fl.carry = r.a[amt - 1];
      end
      ALU_ROR: begin
        res = (amt == 0) ? r.a : ((r.a >> amt) | (r.a << (32 - amt)));
        if (amt != 0) fl.carry = r.a[amt - 1];
      end
      ALU_RRX: begin
        res      = {cin, r.a[31:1]};
        fl.carry = r.a[0];
      end
      default: res = '0;
    endcase
    if (arith) begin
      res = u[31:0];
      ovf = (s > 64'sd2147483647) || (s < -64'sd2147483648);
      if (r.aluOp == ALU_QADD || r.aluOp == ALU_QSUB) begin
        fl.saturated = ovf;
        if (ovf) res = (s > 0) ? `SAT_MAX : `SAT_MIN;
      end else begin
        fl.overflow = ovf;
      end
    end
    fl.neg  = res[31];
    fl.zero = (res == 0);
  endfunction

  function automatic void macModel(input execReq_t r, input aluFlags_t st,
                                   output logic [63:0] p, output aluFlags_t fl);
    logic [63:0] acc;
    logic        longForm;
    acc = {r.accHi, r.accLo};
    case (r.macOp)
      MAC_MLA:   p = {32'd0, r.a * r.b + r.accLo};
      MAC_MLS:   p = {32'd0, r.accLo - r.a * r.b};
      MAC_UMULL: p = {32'd0, r.a} * {32'd0, r.b};
      MAC_UMLAL: p = {32'd0, r.a} * {32'd0, r.b} + acc;
      MAC_SMULL: p = longint'($signed(r.a)) * longint'($signed(r.b));
      default:   p = longint'($signed(r.a)) * longint'($signed(r.b)) + acc;
    endcase
    longForm = (r.macOp != MAC_MLA) && (r.macOp != MAC_MLS);
    fl      = st;
    fl.neg  = longForm ? p[63] : p[31];
    fl.zero = longForm ? (p[63:32] == 0) : (p[31:0] == 0);
  endfunction

  function automatic void expectedFor(input execReq_t r, input aluFlags_t st,
                                      output execResp_t resp, output aluFlags_t nextSt);
    logic [31:0] res;
    logic [63:0] p;
    aluFlags_t   fl;
    if (r.useMac) begin
      macModel(r, st, p, fl);
      resp.resultLo = p[31:0];
      resp.resultHi = p[63:32];
    end else begin
      aluModel(r, st.carry, res, fl);
      resp.resultLo = res;
      resp.resultHi = '0;
    end
    resp.flags = fl;
    nextSt     = st;
    if (r.setFlags) begin
      nextSt           = fl;
      nextSt.saturated = fl.saturated | st.saturated;
    end
  endfunction

  // Full four-phase handshake with an optional hold of req after ack
  task automatic runOp(input execReq_t r, input string name, input int holdCycles);
    execResp_t resp;
    aluFlags_t nextSt;
    expectedFor(r, modelStatus, resp, nextSt);
    @(posedge clk);
    testName    <= name;
    expResp     <= resp;
    expStatus   <= nextSt;
    curUseMac   <= r.useMac;
    curSetFlags <= r.setFlags;
    request     <= r;
    req         <= 1'b1;
    modelStatus = nextSt;
    @(posedge clk);
    while (!ack) @(posedge clk);
    repeat (holdCycles) @(posedge clk);
    req <= 1'b0;
    @(posedge clk);
    while (ack) @(posedge clk);
  endtask

  task automatic applyReset(input int cycles);
    reset <= 1'b1;
    repeat (cycles) @(posedge clk);
    reset <= 1'b0;
    modelStatus = '0;
  endtask

  respCheck: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> (response == expResp))
    else begin
      errorCount++;
      $display("[ERROR] %s response: expected %h, actual %h", testName, expResp, response);
    end

  statusCheck: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> (statusFlags == expStatus))
    else begin
      errorCount++;
      $display("[ERROR] %s statusFlags: expected %b, actual %b", testName, expStatus,
               statusFlags);
    end

  // ALU ops acknowledge exactly two edges after req is first seen
  aluLatency: assert property (@(posedge clk) disable iff (reset)
    ($rose(ack) && !curUseMac) |-> ($past(req, 2) && !$past(req, 3)))
    else begin
      errorCount++;
      $display("%s: ack did not follow req by two edges", testName);
    end

  ackRelease: assert property (@(posedge clk) disable iff (reset)
    (ack && !req) |=> !ack)
    else begin
      errorCount++;
      $display("%s: ack stayed high after req fell", testName);
    end

  heldResponse: assert property (@(posedge clk) disable iff (reset)
    (ack && $past(ack)) |-> (response == expResp && statusFlags == expStatus))
    else begin
      errorCount++;
      $display("[ERROR] %s held response: expected %h/%b, actual %h/%b", testName,
               expResp, expStatus, response, statusFlags);
    end

  flagsKept: assert property (@(posedge clk) disable iff (reset)
    ($rose(ack) && !curSetFlags) |-> $stable(statusFlags))
    else begin
      errorCount++;
      $display("%s: statusFlags changed without setFlags", testName);
    end

  resetState: assert property (@(posedge clk) reset |=> (!ack && statusFlags == '0))
    else begin
      errorCount++;
      $display("ack or statusFlags not cleared by reset");
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the handshake never finished", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [31:0] opA;
    logic [31:0] opB;
    reset       = 1'b1;
    req         = 1'b0;
    request     = '0;
    errorCount  = 0;
    rngState    = 32'hd632_0e14;
    modelStatus = '0;
    expResp     = '0;
    expStatus   = '0;
    curUseMac   = 1'b0;
    curSetFlags = 1'b0;
    testName    = "reset";
    applyReset(RESET_CYCLES);

    // ADC and SBC pick up the carry left by the op before
    for (int i = 0; i < ARITH_REPS; i++) begin
      foreach (arithOps[k]) begin
        runOp(aluReq(arithOps[k], pickOperand(), pickOperand(), 1'b1), arithOps[k].name(), 0);
      end
    end

    runOp(aluReq(ALU_QADD, `SAT_MAX, 32'd1, 1'b1), "QADD max", 0);
    runOp(aluReq(ALU_QADD, `SAT_MIN, 32'hFFFF_FFFF, 1'b1), "QADD min", 0);
    runOp(aluReq(ALU_QSUB, `SAT_MIN, 32'd1, 1'b1), "QSUB min", 0);
    runOp(aluReq(ALU_QSUB, `SAT_MAX, 32'hFFFF_FFFF, 1'b1), "QSUB max", 0);
    for (int i = 0; i < SAT_REPS; i++) begin
      runOp(aluReq(i[0] ? ALU_QSUB : ALU_QADD, pickOperand(), pickOperand(), 1'b1),
            "QADD/QSUB", 0);
    end

    runOp(aluReq(ALU_UDIV, nextRandom(), 32'd0, 1'b1), "UDIV by zero", 0);
    runOp(aluReq(ALU_SDIV, nextRandom(), 32'd0, 1'b1), "SDIV by zero", 0);
    for (int i = 0; i < DIV_REPS; i++) begin
      opA = pickOperand();
      opB = pickOperand();
      // Most negative value over minus one has no 32-bit quotient
      if (opA == `SAT_MIN && opB == 32'hFFFF_FFFF) opB = 32'd3;
      runOp(aluReq(ALU_UDIV, opA, opB, 1'b1), "UDIV", 0);
      runOp(aluReq(ALU_SDIV, opA, opB, 1'b1), "SDIV", 0);
    end

    for (int i = 0; i < LOGIC_REPS; i++) begin
      foreach (logicOps[k]) begin
        runOp(aluReq(logicOps[k], pickOperand(), pickOperand(), 1'b1), logicOps[k].name(), 0);
      end
    end

    // Random upper bits of b around the shift amount in b[4:0]
    foreach (shiftOps[k]) begin
      for (int amt = 0; amt < 32; amt++) begin
        opB = (nextRandom() & 32'hFFFF_FFE0) | 32'(amt);
        runOp(aluReq(shiftOps[k], nextRandom(), opB, 1'b1),
              $sformatf("%s by %0d", shiftOps[k].name(), amt), 0);
      end
    end
    for (int i = 0; i < RRX_REPS; i++) begin
      runOp(aluReq(ALU_RRX, pickOperand(), 32'd0, 1'b1), "RRX", 0);
    end

    for (int i = 0; i < MAC_REPS; i++) begin
      foreach (macOps[k]) begin
        runOp(macReqFor(macOps[k], pickOperand(), pickOperand(), nextRandom(), nextRandom()),
              macOps[k].name(), 0);
      end
    end

    for (int i = 0; i < FLAG_REPS; i++) begin
      runOp(aluReq(arithOps[i], pickOperand(), pickOperand(), 1'b0), "no setFlags", 0);
    end
    runOp(aluReq(ALU_ADD, nextRandom(), nextRandom(), 1'b1), "held req", HOLD_CYCLES);

    // Q only clears on reset
    applyReset(RESET_CYCLES);
    runOp(aluReq(ALU_ADD, 32'd1, 32'd1, 1'b1), "after reset", 0);

    repeat (4) @(posedge clk);
    $display("Checks finished with %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
hdl/exec_pkg.sv
hdl/alu.sv
hdl/mac.sv
hdl/execSequencer.sv
hdl/execStage.sv
testbench/tb_execStage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_execStage -f sim.f \
  || { echo "Verilator build failed"; exit 1; }

simOutput="$(./obj_dir/Vtb_execStage 2>&1)"
echo "$simOutput"

echo "$simOutput" | grep -qx "TB PASSED" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
